//--- tb.f
logic/xbar_pkg.sv
logic/xbar_addr_decode.sv
logic/xbar_rr_arbiter.sv
logic/xbar_mem_port.sv
logic/xbar_resp_route.sv
logic/xbar_top.sv
bench/tb_mem_model.sv
bench/xbar_chk.sv
bench/tb_xbar.sv

//--- Bender.yml
package:
  name: xbar

sources:
  - logic/xbar_pkg.sv
  - logic/xbar_addr_decode.sv
  - logic/xbar_rr_arbiter.sv
  - logic/xbar_mem_port.sv
  - logic/xbar_resp_route.sv
  - logic/xbar_top.sv
  - target: simulation
    files:
      - bench/tb_mem_model.sv
      - bench/xbar_chk.sv
      - bench/tb_xbar.sv

//--- bench/tb_xbar.sv
module tb_xbar import xbar_pkg::*; ();

  localparam int DRV_DLY = 2;   // after rising edge
  localparam int TIMEOUT = 60;  // cycles per wait

  typedef struct {
    int                mst;
    bit                sec;      // other master reads addr ^ 0x40 at once
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
    logic              exp_err;
  } stim_t;

  logic     clk;
  logic     rstn;
  logic     stall_iram;
  obi_req_t mreq_drv [N_MSTR];
  logic     data_gnt, dbg_gnt;
  obi_rsp_t data_rsp, dbg_rsp;
  mem_req_t iram_req, dram_req;
  mem_rsp_t iram_rsp, dram_rsp;

  stim_t             stim [15];
  logic [DATA_W-1:0] ref_mem [logic [29:0]];
  int                errors;
  int                checks;
  int                tests;
  bit                hung;

  xbar_top dut0 (
    .clk_i      (clk),
    .rstn_i     (rstn),
    .data_req_i (mreq_drv[0]),
    .data_gnt_o (data_gnt),
    .data_rsp_o (data_rsp),
    .dbg_req_i  (mreq_drv[1]),
    .dbg_gnt_o  (dbg_gnt),
    .dbg_rsp_o  (dbg_rsp),
    .iram_req_o (iram_req),
    .iram_rsp_i (iram_rsp),
    .dram_req_o (dram_req),
    .dram_rsp_i (dram_rsp)
  );

  tb_mem_model #(.WIN_END(IRAM_END)) u_iram (
    .clk_i (clk), .rstn_i (rstn), .stall_i (stall_iram), .req_i (iram_req), .rsp_o (iram_rsp)
  );

  tb_mem_model #(.WIN_END(DRAM_END)) u_dram (
    .clk_i (clk), .rstn_i (rstn), .stall_i (1'b0), .req_i (dram_req), .rsp_o (dram_rsp)
  );

  always #20 clk = ~clk;

  // ============================================================
  // reference model
  // ============================================================
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return {a[15:0], a[31:16]} ^ a ^ 32'h9e37_79b9;
  endfunction

  function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] a);
    if (ref_mem.exists(a[31:2])) return ref_mem[a[31:2]];
    return fill_word({a[31:2], 2'b00});
  endfunction

  function automatic bit is_iram(input logic [ADDR_W-1:0] a);
    return a >= IRAM_BASE && a < IRAM_END;
  endfunction

  function automatic bit is_dram(input logic [ADDR_W-1:0] a);
    return a >= DRAM_BASE && a < DRAM_END;
  endfunction

  // unmapped, or last word of a window
  function automatic logic expect_err(input logic [ADDR_W-1:0] a);
    if (!is_iram(a) && !is_dram(a)) return 1'b1;
    return a[31:2] == IRAM_END[31:2] - 1 || a[31:2] == DRAM_END[31:2] - 1;
  endfunction

  function automatic logic gnt_of(input int m);
    return (m == 0) ? data_gnt : dbg_gnt;
  endfunction

  function automatic obi_rsp_t rsp_of(input int m);
    return (m == 0) ? data_rsp : dbg_rsp;
  endfunction

  // ============================================================
  // compare tasks
  // ============================================================
  task automatic check_rsp(input string name, input obi_rsp_t act, input obi_rsp_t exp,
                           input bit chk_data);
    checks++;
    if (act.rvalid !== exp.rvalid || act.err !== exp.err ||
        (chk_data && act.rdata !== exp.rdata)) begin
      errors++;
      $display("FAILED t=%0t %s: got %h expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_mem_req(input string name, input mem_req_t act, input mem_req_t exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED t=%0t %s: got %h expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_gnt(input string name, input logic act, input logic exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED t=%0t %s: got %b expected %b", $time, name, act, exp);
    end
  endtask

  // ============================================================
  // one transfer, started just after a rising edge
  // ============================================================
  task automatic do_xfer(input int m, input logic we, input logic [ADDR_W-1:0] addr,
                         input logic [BE_W-1:0] be, input logic [DATA_W-1:0] wdata,
                         input logic exp_err);
    obi_rsp_t          exp;
    mem_req_t          exp_mem;
    logic [DATA_W-1:0] word;
    int                waited;
    bit                chk_data;
    mreq_drv[m] = '{req: 1'b1, addr: addr, be: be, we: we, wdata: wdata};
    waited = 0;
    @(negedge clk);
    // unmapped is granted in the request cycle
    if (!is_iram(addr) && !is_dram(addr)) begin
      check_gnt((m == 0) ? "data_gnt_o" : "dbg_gnt_o", gnt_of(m), 1'b1);
    end
    while (!gnt_of(m) && waited < TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    if (waited >= TIMEOUT) begin
      $display("master %0d got no grant for address %h", m, addr);
      hung = 1'b1;
      errors++;
      mreq_drv[m] = '0;
      return;
    end
    exp_mem = '{en: 1'b1, addr: addr, be: be, we: we, wdata: wdata};
    if (is_iram(addr)) check_mem_req("iram_req_o", iram_req, exp_mem);
    if (is_dram(addr)) check_mem_req("dram_req_o", dram_req, exp_mem);
    word     = ref_read(addr);
    exp      = '{rvalid: 1'b1, err: exp_err, rdata: word};
    chk_data = !we && !exp_err;
    if (!is_iram(addr) && !is_dram(addr)) begin
      exp.rdata = '0;
      chk_data  = 1'b1;
    end
    @(posedge clk);
    if (we && !exp_err) begin
      for (int b = 0; b < BE_W; b++) begin
        if (be[b]) word[8*b +: 8] = wdata[8*b +: 8];
      end
      ref_mem[addr[31:2]] = word;
    end
    #DRV_DLY mreq_drv[m] = '0;
    @(negedge clk);
    check_rsp((m == 0) ? "data_rsp_o" : "dbg_rsp_o", rsp_of(m), exp, chk_data);
  endtask

  task automatic apply_reset();
    rstn = 1'b0;
    repeat (10) @(posedge clk);
    #DRV_DLY rstn = 1'b1;
  endtask

  task automatic report(input string name, input int err_before);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "errors");
  endtask

  task automatic load_stim();
    stim[0]  = '{0, 0, 1'b1, 32'h2004_0010, 4'hF, 32'h1122_3344, 1'b0};
    stim[1]  = '{0, 0, 1'b0, 32'h2004_0010, 4'h0, 32'h0,         1'b0};
    stim[2]  = '{0, 0, 1'b1, 32'h2004_0010, 4'h5, 32'hAABB_CCDD, 1'b0};
    stim[3]  = '{0, 0, 1'b0, 32'h2004_0010, 4'h0, 32'h0,         1'b0};
    stim[4]  = '{1, 0, 1'b1, 32'h200F_0100, 4'hC, 32'h5566_7788, 1'b0};
    stim[5]  = '{1, 0, 1'b0, 32'h200F_0100, 4'h0, 32'h0,         1'b0};
    stim[6]  = '{0, 1, 1'b1, 32'h200F_0200, 4'hF, 32'hCAFE_F00D, 1'b0};
    stim[7]  = '{1, 1, 1'b0, 32'h200F_0200, 4'h0, 32'h0,         1'b0};
    stim[8]  = '{1, 0, 1'b1, 32'h2008_0000, 4'h3, 32'h0BAD_BEEF, 1'b0};
    stim[9]  = '{1, 1, 1'b0, 32'h2008_0000, 4'h0, 32'h0,         1'b0};
    stim[10] = '{0, 1, 1'b0, 32'h1000_0000, 4'h0, 32'h0,         1'b1};
    stim[11] = '{1, 0, 1'b1, 32'h3000_0000, 4'hF, 32'h1234_5678, 1'b1};
    stim[12] = '{0, 0, 1'b0, 32'h200B_FFFC, 4'h0, 32'h0,         1'b1};
    stim[13] = '{1, 0, 1'b1, 32'h200F_FFFC, 4'hF, 32'hDEAD_0001, 1'b1};
    stim[14] = '{0, 1, 1'b0, 32'h200F_FFFC, 4'h0, 32'h0,         1'b1};
  endtask

  // ============================================================
  // sequence
  // ============================================================
  initial begin
    int                err0;
    int                seen;
    int                waited;
    bit                seen_rsp;
    logic [ADDR_W-1:0] a2;
    clk         = 1'b0;
    rstn        = 1'b0;
    stall_iram  = 1'b0;
    mreq_drv[0] = '0;
    mreq_drv[1] = '0;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    hung        = 1'b0;
    load_stim();
    apply_reset();

    // outputs idle after reset
    err0 = errors;
    @(negedge clk);
    check_gnt("data_gnt_o", data_gnt, 1'b0);
    check_gnt("dbg_gnt_o", dbg_gnt, 1'b0);
    check_rsp("data_rsp_o", data_rsp, '0, 1'b1);
    check_rsp("dbg_rsp_o", dbg_rsp, '0, 1'b1);
    check_mem_req("iram_req_o", iram_req, '0);
    check_mem_req("dram_req_o", dram_req, '0);
    report("idle after reset", err0);

    // both masters on iram, grants alternate from master 0
    err0 = errors;
    @(posedge clk);
    #DRV_DLY;
    mreq_drv[0] = '{req: 1'b1, addr: 32'h2004_0100, be: 4'hF, we: 1'b0, wdata: '0};
    mreq_drv[1] = '{req: 1'b1, addr: 32'h2004_0200, be: 4'hF, we: 1'b0, wdata: '0};
    seen   = 0;
    waited = 0;
    while (seen < 6 && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
      if (data_gnt || dbg_gnt) begin
        check_gnt("data_gnt_o", data_gnt, seen % 2 == 0);
        check_gnt("dbg_gnt_o", dbg_gnt, seen % 2 == 1);
        seen++;
      end
    end
    if (seen < 6) begin
      $display("round robin saw only %0d grants", seen);
      hung = 1'b1;
      errors++;
    end
    @(posedge clk);
    #DRV_DLY;
    mreq_drv[0] = '0;
    mreq_drv[1] = '0;
    repeat (2) @(posedge clk);
    #DRV_DLY;
    report("round robin", err0);

    // table
    foreach (stim[i]) begin
      err0 = errors;
      a2   = stim[i].addr ^ 32'h40;
      if (stim[i].sec) begin
        fork
          do_xfer(stim[i].mst, stim[i].we, stim[i].addr, stim[i].be, stim[i].wdata,
                  stim[i].exp_err);
          do_xfer(1 - stim[i].mst, 1'b0, a2, 4'hF, '0, expect_err(a2));
        join
      end else begin
        do_xfer(stim[i].mst, stim[i].we, stim[i].addr, stim[i].be, stim[i].wdata,
                stim[i].exp_err);
      end
      @(posedge clk);
      #DRV_DLY;
      report($sformatf("stim %0d", i), err0);
    end

    // back-pressure holds en and grant low
    err0 = errors;
    stall_iram  = 1'b1;
    mreq_drv[1] = '{req: 1'b1, addr: 32'h2004_0300, be: 4'hA, we: 1'b1, wdata: 32'h9988_7766};
    repeat (4) begin
      @(negedge clk);
      check_gnt("dbg_gnt_o", dbg_gnt, 1'b0);
      check_mem_req("iram_req_o", iram_req, '0);
    end
    @(posedge clk);
    #DRV_DLY stall_iram = 1'b0;
    do_xfer(1, 1'b1, 32'h2004_0300, 4'hA, 32'h9988_7766, 1'b0);
    @(posedge clk);
    #DRV_DLY;
    do_xfer(1, 1'b0, 32'h2004_0300, 4'hF, '0, 1'b0);
    @(posedge clk);
    #DRV_DLY;
    report("ready stall", err0);

    // iram to dram switch waits for the iram response
    err0 = errors;
    do_xfer(0, 1'b1, 32'h200F_0400, 4'hF, 32'h4242_4242, 1'b0);
    @(posedge clk);
    #DRV_DLY;
    mreq_drv[0] = '{req: 1'b1, addr: 32'h2004_0400, be: 4'hF, we: 1'b0, wdata: '0};
    waited = 0;
    @(negedge clk);
    while (!data_gnt && waited < TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    if (!data_gnt) begin
      $display("data master never got the iram grant");
      hung = 1'b1;
      errors++;
    end
    @(posedge clk);
    #DRV_DLY;
    mreq_drv[0] = '{req: 1'b1, addr: 32'h200F_0400, be: 4'hF, we: 1'b0, wdata: '0};
    seen_rsp = 1'b0;
    waited   = 0;
    @(negedge clk);
    seen_rsp = data_rsp.rvalid;
    while (!data_gnt && waited < TIMEOUT) begin
      waited++;
      @(negedge clk);
      seen_rsp = seen_rsp | data_rsp.rvalid;
    end
    if (waited >= TIMEOUT) begin
      $display("data master never got the dram grant");
      hung = 1'b1;
      errors++;
    end else if (!seen_rsp) begin
      $display("dram grant came before the iram response at %0t", $time);
      errors++;
    end
    @(posedge clk);
    #DRV_DLY mreq_drv[0] = '0;
    @(negedge clk);
    check_rsp("data_rsp_o", data_rsp, '{rvalid: 1'b1, err: 1'b0, rdata: 32'h4242_4242}, 1'b1);
    report("target switch", err0);

    $display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
    if (errors == 0 && !hung) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- bench/xbar_chk.sv
module xbar_chk import xbar_pkg::*; (
  input logic                            clk_i,
  input logic                            rstn_i,
  input logic                            data_gnt_o,
  input logic                            dbg_gnt_o,
  input obi_rsp_t                        data_rsp_o,
  input obi_rsp_t                        dbg_rsp_o,
  input mem_req_t                        iram_req_o,
  input mem_rsp_t                        iram_rsp_i,
  input mem_req_t                        dram_req_o,
  input mem_rsp_t                        dram_rsp_i,
  input logic [N_MEM-1:0][N_MSTR-1:0]    port_gnt
);

  // response one cycle after grant
  a_data_rvalid: assert property (@(posedge clk_i) disable iff (!rstn_i)
    data_gnt_o |=> data_rsp_o.rvalid) else $error("data rvalid missing after grant");

  a_dbg_rvalid: assert property (@(posedge clk_i) disable iff (!rstn_i)
    dbg_gnt_o |=> dbg_rsp_o.rvalid) else $error("dbg rvalid missing after grant");

  // no enable without ready
  a_iram_en: assert property (@(posedge clk_i) disable iff (!rstn_i)
    iram_req_o.en |-> iram_rsp_i.ready) else $error("iram en while not ready");

  a_dram_en: assert property (@(posedge clk_i) disable iff (!rstn_i)
    dram_req_o.en |-> dram_rsp_i.ready) else $error("dram en while not ready");

  a_iram_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $onehot0(port_gnt[TGT_IRAM])) else $error("iram grants not one-hot");

  a_dram_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $onehot0(port_gnt[TGT_DRAM])) else $error("dram grants not one-hot");

endmodule

bind xbar_top xbar_chk u_chk (.*);

//--- bench/tb_mem_model.sv
module tb_mem_model import xbar_pkg::*; #(
  parameter logic [ADDR_W-1:0] WIN_END = '0  // exclusive window end
) (
  input  logic     clk_i,
  input  logic     rstn_i,
  input  logic     stall_i,
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o
);

  logic [DATA_W-1:0] mem [logic [29:0]];
  logic [31:0]       rnd_q;
  logic [DATA_W-1:0] rdata_q;
  logic              err_q;
  logic [DATA_W-1:0] cur;
  logic              hit_err;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return {a[15:0], a[31:16]} ^ a ^ 32'h9e37_79b9;
  endfunction

  assign rsp_o.ready = !stall_i && (rnd_q[2:0] != 3'd0);  // about one stall in eight
  assign rsp_o.error = err_q;
  assign rsp_o.rdata = rdata_q;
  assign hit_err     = req_i.addr[31:2] == WIN_END[31:2] - 1;  // last word

  always @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      rnd_q   <= 32'd37705;
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else begin
      rnd_q <= xorshift(rnd_q);
      if (req_i.en && rsp_o.ready) begin
        cur = mem.exists(req_i.addr[31:2]) ? mem[req_i.addr[31:2]]
                                           : fill_word({req_i.addr[31:2], 2'b00});
        rdata_q <= cur;
        err_q   <= hit_err;
        if (req_i.we && !hit_err) begin
          for (int b = 0; b < BE_W; b++) begin
            if (req_i.be[b]) cur[8*b +: 8] = req_i.wdata[8*b +: 8];
          end
          mem[req_i.addr[31:2]] = cur;
        end
      end
    end
  end

endmodule

//--- logic/xbar_top.sv
module xbar_top import xbar_pkg::*; (
  input  logic     clk_i,
  input  logic     rstn_i,

  // cpu data port, master 0
  input  obi_req_t data_req_i,
  output logic     data_gnt_o,
  output obi_rsp_t data_rsp_o,

  // debug port, master 1
  input  obi_req_t dbg_req_i,
  output logic     dbg_gnt_o,
  output obi_rsp_t dbg_rsp_o,

  output mem_req_t iram_req_o,
  input  mem_rsp_t iram_rsp_i,

  output mem_req_t dram_req_o,
  input  mem_rsp_t dram_rsp_i
);

  // per master
  obi_req_t [N_MSTR-1:0]            mreq;
  logic     [N_MSTR-1:0]            mgnt;
  obi_rsp_t [N_MSTR-1:0]            mrsp;
  logic     [N_MSTR-1:0][N_MEM-1:0] tgt_req;
  logic     [N_MSTR-1:0][N_MEM-1:0] mem_gnt;
  tgt_vec_t [N_MSTR-1:0]            pending;
  tgt_vec_t [N_MSTR-1:0]            gnt_tgt;

  // per memory
  logic     [N_MEM-1:0][N_MSTR-1:0] port_req;
  logic     [N_MEM-1:0][N_MSTR-1:0] port_gnt;
  obi_rsp_t [N_MEM-1:0]             port_rsp;
  mem_req_t [N_MEM-1:0]             mem_req;
  mem_rsp_t [N_MEM-1:0]             mem_rsp;

  assign mreq[0]    = data_req_i;
  assign mreq[1]    = dbg_req_i;
  assign data_gnt_o = mgnt[0];
  assign dbg_gnt_o  = mgnt[1];
  assign data_rsp_o = mrsp[0];
  assign dbg_rsp_o  = mrsp[1];

  assign iram_req_o        = mem_req[TGT_IRAM];
  assign dram_req_o        = mem_req[TGT_DRAM];
  assign mem_rsp[TGT_IRAM] = iram_rsp_i;
  assign mem_rsp[TGT_DRAM] = dram_rsp_i;

  // ============================================================
  // master side
  // ============================================================
  for (genvar m = 0; m < N_MSTR; m++) begin : g_mstr
    xbar_addr_decode u_dec (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .mreq_i      (mreq[m]),
      .pending_i   (pending[m]),
      .rsp_valid_i (mrsp[m].rvalid),
      .mem_gnt_i   (mem_gnt[m]),
      .tgt_req_o   (tgt_req[m]),
      .gnt_o       (mgnt[m]),
      .gnt_tgt_o   (gnt_tgt[m])
    );

    xbar_resp_route u_route (
      .clk_i     (clk_i),
      .rstn_i    (rstn_i),
      .gnt_i     (mgnt[m]),
      .gnt_tgt_i (gnt_tgt[m]),
      .mem_rsp_i (port_rsp),
      .pending_o (pending[m]),
      .rsp_o     (mrsp[m])
    );

    // request bits regrouped per memory, grants back per master
    for (genvar s = 0; s < N_MEM; s++) begin : g_xpose
      assign port_req[s][m] = tgt_req[m][s];
      assign mem_gnt[m][s]  = port_gnt[s][m];
    end
  end

  // ============================================================
  // memory side
  // ============================================================
  for (genvar s = 0; s < N_MEM; s++) begin : g_mem
    xbar_mem_port u_port (
      .clk_i     (clk_i),
      .rstn_i    (rstn_i),
      .mreq_i    (mreq),
      .req_i     (port_req[s]),
      .gnt_o     (port_gnt[s]),
      .mem_req_o (mem_req[s]),
      .mem_rsp_i (mem_rsp[s]),
      .rsp_o     (port_rsp[s])
    );
  end

endmodule

//--- logic/xbar_resp_route.sv
module xbar_resp_route import xbar_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rstn_i,
  input  logic                 gnt_i,
  input  tgt_vec_t             gnt_tgt_i,
  input  obi_rsp_t [N_MEM-1:0] mem_rsp_i,
  output tgt_vec_t             pending_o,
  output obi_rsp_t             rsp_o
);

  tgt_vec_t pend_q;

  // ============================================================
  // pending target
  // ============================================================
  // a new grant replaces the old entry in the same edge
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      pend_q <= '0;
    end else if (gnt_i) begin
      pend_q <= gnt_tgt_i;
    end else if (rsp_o.rvalid) begin
      pend_q <= '0;
    end
  end

  assign pending_o = pend_q;

  // ============================================================
  // response select
  // ============================================================
  always_comb begin
    rsp_o = '0;
    for (int i = 0; i < N_MEM; i++) begin
      if (pend_q[i]) rsp_o = mem_rsp_i[i];
    end

    // unmapped access answers with an error and no data
    if (pend_q[TGT_NONE]) begin
      rsp_o.rvalid = 1'b1;
      rsp_o.err    = 1'b1;
      rsp_o.rdata  = '0;
    end
  end

endmodule

//--- logic/xbar_mem_port.sv
module xbar_mem_port import xbar_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  obi_req_t [N_MSTR-1:0] mreq_i,
  input  logic     [N_MSTR-1:0] req_i,
  output logic     [N_MSTR-1:0] gnt_o,
  output mem_req_t              mem_req_o,
  input  mem_rsp_t              mem_rsp_i,
  output obi_rsp_t              rsp_o
);

  logic [N_MSTR-1:0] sel;
  logic              gnt_any;
  logic              rvalid_q;

  xbar_rr_arbiter u_arb (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .req_i  (req_i),
    .gnt_i  (gnt_any),
    .sel_o  (sel)
  );

  // no grant while the memory stalls
  assign gnt_o   = sel & {N_MSTR{mem_rsp_i.ready}};
  assign gnt_any = |gnt_o;

  // ============================================================
  // request mux
  // ============================================================
  always_comb begin
    mem_req_o    = '0;
    mem_req_o.en = gnt_any;
    for (int i = 0; i < N_MSTR; i++) begin
      if (gnt_o[i]) begin
        mem_req_o.addr  = mreq_i[i].addr;
        mem_req_o.be    = mreq_i[i].be;
        mem_req_o.we    = mreq_i[i].we;
        mem_req_o.wdata = mreq_i[i].wdata;
      end
    end
  end

  // ============================================================
  // response
  // ============================================================
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt_any;
    end
  end

  // memory returns data the cycle after it accepts
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.err    = mem_rsp_i.error;
  assign rsp_o.rdata  = mem_rsp_i.rdata;

endmodule

//--- logic/xbar_rr_arbiter.sv
module xbar_rr_arbiter import xbar_pkg::*; (
  input  logic              clk_i,
  input  logic              rstn_i,
  input  logic [N_MSTR-1:0] req_i,
  input  logic              gnt_i,   // transfer taken this cycle
  output logic [N_MSTR-1:0] sel_o
);

  logic [N_MSTR-1:0] last_q;   // one-hot, last granted master
  logic [N_MSTR-1:0] mask_hi;
  logic [N_MSTR-1:0] req_hi;
  logic [N_MSTR-1:0] pick;

  // ============================================================
  // choice
  // ============================================================
  always_comb begin
    // masters strictly above the last winner
    mask_hi[0] = 1'b0;
    for (int i = 1; i < N_MSTR; i++) begin
      mask_hi[i] = mask_hi[i-1] | last_q[i-1];
    end

    req_hi = req_i & mask_hi;
    pick   = (|req_hi) ? req_hi : req_i;  // wrap around

    sel_o = pick & (~pick + 1'b1);  // keep lowest bit
  end

  // ============================================================
  // pointer
  // ============================================================
  // last winner starts at the top so master 0 goes first
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      last_q <= {1'b1, {(N_MSTR-1){1'b0}}};
    end else if (gnt_i) begin
      last_q <= sel_o;
    end
  end

endmodule

//--- logic/xbar_addr_decode.sv
module xbar_addr_decode import xbar_pkg::*; (
  input  logic             clk_i,
  input  logic             rstn_i,
  input  obi_req_t         mreq_i,
  input  tgt_vec_t         pending_i,
  input  logic             rsp_valid_i,
  input  logic [N_MEM-1:0] mem_gnt_i,
  output logic [N_MEM-1:0] tgt_req_o,
  output logic             gnt_o,
  output tgt_vec_t         gnt_tgt_o
);

  tgt_e     dec_tgt;
  tgt_e     tgt_sel;
  tgt_e     lock_tgt_q;
  logic     lock_q;
  logic     allow;
  tgt_vec_t dec_vec;
  tgt_vec_t fwd_vec;

  // window compare
  always_comb begin
    if (mreq_i.addr >= IRAM_BASE && mreq_i.addr < IRAM_END) begin
      dec_tgt = TGT_IRAM;
    end else if (mreq_i.addr >= DRAM_BASE && mreq_i.addr < DRAM_END) begin
      dec_tgt = TGT_DRAM;
    end else begin
      dec_tgt = TGT_NONE;
    end
  end

  // a waiting request keeps the target it started with
  assign tgt_sel = lock_q ? lock_tgt_q : dec_tgt;

  always_comb begin
    dec_vec = '0;
    if (mreq_i.req) dec_vec[tgt_sel] = 1'b1;
  end

  // switching targets waits for the previous response
  assign allow   = (pending_i == '0) || (pending_i == dec_vec) || rsp_valid_i;
  assign fwd_vec = allow ? dec_vec : '0;

  assign tgt_req_o = fwd_vec[N_MEM-1:0];
  assign gnt_o     = |(mem_gnt_i & tgt_req_o) | fwd_vec[TGT_NONE];  // unmapped grants itself
  assign gnt_tgt_o = gnt_o ? fwd_vec : '0;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= mreq_i.req & ~gnt_o;
    end
  end

  always_ff @(posedge clk_i) begin
    lock_tgt_q <= tgt_sel;
  end

endmodule

//--- logic/xbar_pkg.sv
package xbar_pkg;

  // ============================================================
  // bus sizes
  // ============================================================
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = 4;
  localparam int N_MSTR = 2;  // cpu data, debug
  localparam int N_MEM  = 2;  // iram, dram

  // ============================================================
  // address map, end addresses exclusive
  // ============================================================
  localparam logic [ADDR_W-1:0] IRAM_BASE = 32'h2004_0000;
  localparam logic [ADDR_W-1:0] IRAM_END  = 32'h200C_0000;
  localparam logic [ADDR_W-1:0] DRAM_BASE = 32'h200F_0000;
  localparam logic [ADDR_W-1:0] DRAM_END  = 32'h2010_0000;

  // target value doubles as memory port index
  typedef enum logic [1:0] {
    TGT_IRAM = 2'd0,
    TGT_DRAM = 2'd1,
    TGT_NONE = 2'd2
  } tgt_e;

  // one-hot over memory ports, top bit for unmapped
  typedef logic [N_MEM:0] tgt_vec_t;

  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be;
    logic              we;
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic              rvalid;
    logic              err;
    logic [DATA_W-1:0] rdata;
  } obi_rsp_t;

  typedef struct packed {
    logic              en;
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be;
    logic              we;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic              ready;
    logic              error;
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

endpackage
